// File: common/db_pkg.sv
/* Shared sizes and payload types for the key-value lookup table.
   Imported by the muxes, the store, the top level and the testbench. */

package db_pkg;

    // ======================================================================
    // Table sizes
    // ======================================================================

    localparam int KEY_W    = 8;
    localparam int VALUE_W  = 32;

    // Keys from DB_DEPTH up to the top of the key space are out of range
    localparam int DB_DEPTH = 192;

    // ======================================================================
    // Mux context FIFO
    // ======================================================================

    // Must be a power of two so that the pointers wrap on their own
    localparam int CTXT_DEPTH = 4;
    localparam int CTXT_PTR_W = $clog2(CTXT_DEPTH);
    localparam int CTXT_CNT_W = CTXT_PTR_W + 1;

    // ======================================================================
    // Payload types
    // ======================================================================

    typedef logic [KEY_W-1:0]   key_t;
    typedef logic [VALUE_W-1:0] value_t;

    // Update request, 41 bits
    typedef struct packed {
        key_t   key;
        logic   valid;
        value_t value;
    } upd_req_t;

    // Update response, 1 bit
    typedef struct packed {
        logic error;
    } upd_rsp_t;

    // Query request, 8 bits
    typedef struct packed {
        key_t key;
    } qry_req_t;

    // Query response, 34 bits
    typedef struct packed {
        logic   error;
        logic   valid;
        value_t value;
    } qry_rsp_t;

endpackage : db_pkg

// File: design/db_prio_mux.sv
/* Strict-priority two-to-one mux for one req/rdy/ack channel. A small FIFO of
   select bits sends every ack and response back to the side that was accepted. */

`timescale 1ns/1ps

module db_prio_mux
    import db_pkg::*;
#(
    parameter type REQ_T = logic,
    parameter type RSP_T = logic
) (
    input  logic clk,
    input  logic srst,

    // High-priority requester
    input  logic hi_req,
    input  REQ_T hi_req_data,
    output logic hi_rdy,
    output logic hi_ack,
    output RSP_T hi_rsp,

    // Low-priority requester
    input  logic lo_req,
    input  REQ_T lo_req_data,
    output logic lo_rdy,
    output logic lo_ack,
    output RSP_T lo_rsp,

    // Downstream responder
    output logic out_req,
    output REQ_T out_req_data,
    input  logic out_rdy,
    input  logic out_ack,
    input  RSP_T out_rsp
);

    // ======================================================================
    // Signals
    // ======================================================================

    // One bit per open transaction that is set when the lo side was accepted
    logic [CTXT_DEPTH-1:0] ctxt_sel;
    logic [CTXT_PTR_W-1:0] ctxt_wr_ptr;
    logic [CTXT_PTR_W-1:0] ctxt_rd_ptr;
    logic [CTXT_CNT_W-1:0] ctxt_cnt;
    logic                  ctxt_full;

    logic lo_sel;
    logic accept;
    logic rsp_to_lo;

    // ======================================================================
    // Request path
    // ======================================================================

    // The hi side wins whenever it asks
    assign lo_sel    = !hi_req;
    assign ctxt_full = (ctxt_cnt == CTXT_CNT_W'(CTXT_DEPTH));

    // No new request leaves while there is no room to record its origin
    assign out_req      = (hi_req || lo_req) && !ctxt_full;
    assign out_req_data = lo_sel ? lo_req_data : hi_req_data;

    assign hi_rdy = hi_req && out_rdy && !ctxt_full;
    assign lo_rdy = lo_sel && out_rdy && !ctxt_full;

    assign accept = out_req && out_rdy;

    // ======================================================================
    // Context FIFO
    // ======================================================================

    always_ff @(posedge clk) begin
        if (srst) begin
            ctxt_wr_ptr <= '0;
            ctxt_rd_ptr <= '0;
            ctxt_cnt    <= '0;
        end else begin
            if (accept) begin
                ctxt_wr_ptr <= ctxt_wr_ptr + 1'b1;
            end
            if (out_ack) begin
                ctxt_rd_ptr <= ctxt_rd_ptr + 1'b1;
            end
            case ({accept, out_ack})
                2'b10:   ctxt_cnt <= ctxt_cnt + 1'b1;
                2'b01:   ctxt_cnt <= ctxt_cnt - 1'b1;
                default: ctxt_cnt <= ctxt_cnt;
            endcase
        end
    end

    // Origin of each accepted request goes into the slot at the write pointer
    always_ff @(posedge clk) begin
        if (accept) begin
            ctxt_sel[ctxt_wr_ptr] <= lo_sel;
        end
    end

    // ======================================================================
    // Response path
    // ======================================================================

    // Oldest open transaction owns the current ack
    assign rsp_to_lo = ctxt_sel[ctxt_rd_ptr];

    assign hi_ack = out_ack && !rsp_to_lo;
    assign lo_ack = out_ack && rsp_to_lo;

    // Payload only shows up on the owning side
    always_comb begin
        hi_rsp = out_rsp;
        lo_rsp = out_rsp;
        if (rsp_to_lo) begin
            hi_rsp = '0;
        end else begin
            lo_rsp = '0;
        end
    end

endmodule : db_prio_mux

// File: db_store/db_store.sv
/* Direct-mapped key-value table with one update port and one query port.
   Cleared by a sweep after reset; every request is acked two cycles later. */

`timescale 1ns/1ps

module db_store
    import db_pkg::*;
(
    input  logic     clk,
    input  logic     srst,

    // Update port
    input  logic     upd_req,
    input  upd_req_t upd_req_data,
    output logic     upd_rdy,
    output logic     upd_ack,
    output upd_rsp_t upd_rsp,

    // Query port
    input  logic     qry_req,
    input  qry_req_t qry_req_data,
    output logic     qry_rdy,
    output logic     qry_ack,
    output qry_rsp_t qry_rsp
);

    // ======================================================================
    // Signals
    // ======================================================================

    // Entry layout is {valid, value}
    logic [VALUE_W:0] mem [DB_DEPTH];

    // Clearing sweep
    logic sweep_active;
    key_t sweep_addr;

    // Update pipeline
    logic     upd_accept;
    logic     upd_s1_vld;
    logic     upd_s1_err;
    upd_req_t upd_s1_data;
    logic     upd_s2_vld;
    logic     upd_s2_err;

    // Query pipeline
    logic     qry_accept;
    logic     qry_s1_vld;
    logic     qry_s1_err;
    key_t     qry_s1_key;
    logic     qry_s2_vld;
    logic     qry_s2_err;
    logic     qry_s2_valid;
    value_t   qry_s2_value;

    function automatic logic out_of_range(input key_t key);
        return int'(key) >= DB_DEPTH;
    endfunction

    // ======================================================================
    // Reset sweep
    // ======================================================================

    // One entry per cycle, DB_DEPTH cycles in all
    always_ff @(posedge clk) begin
        if (srst) begin
            sweep_active <= 1'b1;
            sweep_addr   <= '0;
        end else if (sweep_active) begin
            sweep_addr <= sweep_addr + 1'b1;
            if (sweep_addr == key_t'(DB_DEPTH - 1)) begin
                sweep_active <= 1'b0;
            end
        end
    end

    // Both ports stay closed until the table is clean
    assign upd_rdy = !sweep_active;
    assign qry_rdy = !sweep_active;

    assign upd_accept = upd_req && upd_rdy;
    assign qry_accept = qry_req && qry_rdy;

    // ======================================================================
    // Pipeline control
    // ======================================================================

    always_ff @(posedge clk) begin
        if (srst) begin
            upd_s1_vld <= 1'b0;
            upd_s2_vld <= 1'b0;
            qry_s1_vld <= 1'b0;
            qry_s2_vld <= 1'b0;
        end else begin
            upd_s1_vld <= upd_accept;
            upd_s2_vld <= upd_s1_vld;
            qry_s1_vld <= qry_accept;
            qry_s2_vld <= qry_s1_vld;
        end
    end

    // ======================================================================
    // Update port
    // ======================================================================

    // Stage 1 holds the request and its range check
    always_ff @(posedge clk) begin
        if (upd_accept) begin
            upd_s1_data <= upd_req_data;
            upd_s1_err  <= out_of_range(upd_req_data.key);
        end
        if (upd_s1_vld) begin
            upd_s2_err <= upd_s1_err;
        end
    end

    // Memory write on the stage 1 to stage 2 edge, sweep has the port first
    always_ff @(posedge clk) begin
        if (sweep_active) begin
            mem[sweep_addr] <= '0;
        end else if (upd_s1_vld && !upd_s1_err) begin
            mem[upd_s1_data.key] <= {upd_s1_data.valid, upd_s1_data.value};
        end
    end

    assign upd_ack = upd_s2_vld;
    assign upd_rsp = '{error: upd_s2_err};

    // ======================================================================
    // Query port
    // ======================================================================

    always_ff @(posedge clk) begin
        if (qry_accept) begin
            qry_s1_key <= qry_req_data.key;
            qry_s1_err <= out_of_range(qry_req_data.key);
        end
    end

    // Read on the same edge as the update write, so a same-cycle pair sees
    // the old entry and a query one cycle behind sees the new one
    always_ff @(posedge clk) begin
        if (qry_s1_vld) begin
            qry_s2_err <= qry_s1_err;
            if (qry_s1_err) begin
                qry_s2_valid <= 1'b0;
                qry_s2_value <= '0;
            end else begin
                {qry_s2_valid, qry_s2_value} <= mem[qry_s1_key];
            end
        end
    end

    assign qry_ack = qry_s2_vld;
    assign qry_rsp = '{error: qry_s2_err, valid: qry_s2_valid, value: qry_s2_value};

endmodule : db_store

// File: design/db_subsystem.sv
/* Top level of the lookup table: cpu and engine clients share the store
   through one priority mux for updates and one for queries. */

`timescale 1ns/1ps

module db_subsystem
    import db_pkg::*;
(
    input  logic   clk,
    input  logic   srst,

    // Control processor updates
    input  logic   cpu_upd_req,
    input  key_t   cpu_upd_key,
    input  logic   cpu_upd_valid,
    input  value_t cpu_upd_value,
    output logic   cpu_upd_rdy,
    output logic   cpu_upd_ack,
    output logic   cpu_upd_error,

    // Packet engine updates
    input  logic   eng_upd_req,
    input  key_t   eng_upd_key,
    input  logic   eng_upd_valid,
    input  value_t eng_upd_value,
    output logic   eng_upd_rdy,
    output logic   eng_upd_ack,
    output logic   eng_upd_error,

    // Control processor queries
    input  logic   cpu_qry_req,
    input  key_t   cpu_qry_key,
    output logic   cpu_qry_rdy,
    output logic   cpu_qry_ack,
    output logic   cpu_qry_error,
    output logic   cpu_qry_valid,
    output value_t cpu_qry_value,

    // Packet engine queries
    input  logic   eng_qry_req,
    input  key_t   eng_qry_key,
    output logic   eng_qry_rdy,
    output logic   eng_qry_ack,
    output logic   eng_qry_error,
    output logic   eng_qry_valid,
    output value_t eng_qry_value
);

    // ======================================================================
    // Client payloads
    // ======================================================================

    upd_req_t cpu_upd_data, eng_upd_data;
    upd_rsp_t cpu_upd_rsp, eng_upd_rsp;
    qry_req_t cpu_qry_data, eng_qry_data;
    qry_rsp_t cpu_qry_rsp, eng_qry_rsp;

    assign cpu_upd_data = '{key: cpu_upd_key, valid: cpu_upd_valid, value: cpu_upd_value};
    assign eng_upd_data = '{key: eng_upd_key, valid: eng_upd_valid, value: eng_upd_value};
    assign cpu_qry_data = '{key: cpu_qry_key};
    assign eng_qry_data = '{key: eng_qry_key};

    assign cpu_upd_error = cpu_upd_rsp.error;
    assign eng_upd_error = eng_upd_rsp.error;

    assign cpu_qry_error = cpu_qry_rsp.error;
    assign cpu_qry_valid = cpu_qry_rsp.valid;
    assign cpu_qry_value = cpu_qry_rsp.value;
    assign eng_qry_error = eng_qry_rsp.error;
    assign eng_qry_valid = eng_qry_rsp.valid;
    assign eng_qry_value = eng_qry_rsp.value;

    // Store side of both muxes
    logic     upd_req, upd_rdy, upd_ack;
    upd_req_t upd_req_data;
    upd_rsp_t upd_rsp;
    logic     qry_req, qry_rdy, qry_ack;
    qry_req_t qry_req_data;
    qry_rsp_t qry_rsp;

    // ======================================================================
    // Instances
    // ======================================================================

    // cpu is the high-priority side on both channels
    db_prio_mux #(
        .REQ_T (upd_req_t),
        .RSP_T (upd_rsp_t)
    ) u_upd_mux (
        .clk          (clk),
        .srst         (srst),
        .hi_req       (cpu_upd_req),
        .hi_req_data  (cpu_upd_data),
        .hi_rdy       (cpu_upd_rdy),
        .hi_ack       (cpu_upd_ack),
        .hi_rsp       (cpu_upd_rsp),
        .lo_req       (eng_upd_req),
        .lo_req_data  (eng_upd_data),
        .lo_rdy       (eng_upd_rdy),
        .lo_ack       (eng_upd_ack),
        .lo_rsp       (eng_upd_rsp),
        .out_req      (upd_req),
        .out_req_data (upd_req_data),
        .out_rdy      (upd_rdy),
        .out_ack      (upd_ack),
        .out_rsp      (upd_rsp)
    );

    db_prio_mux #(
        .REQ_T (qry_req_t),
        .RSP_T (qry_rsp_t)
    ) u_qry_mux (
        .clk          (clk),
        .srst         (srst),
        .hi_req       (cpu_qry_req),
        .hi_req_data  (cpu_qry_data),
        .hi_rdy       (cpu_qry_rdy),
        .hi_ack       (cpu_qry_ack),
        .hi_rsp       (cpu_qry_rsp),
        .lo_req       (eng_qry_req),
        .lo_req_data  (eng_qry_data),
        .lo_rdy       (eng_qry_rdy),
        .lo_ack       (eng_qry_ack),
        .lo_rsp       (eng_qry_rsp),
        .out_req      (qry_req),
        .out_req_data (qry_req_data),
        .out_rdy      (qry_rdy),
        .out_ack      (qry_ack),
        .out_rsp      (qry_rsp)
    );

    db_store u_store (
        .clk          (clk),
        .srst         (srst),
        .upd_req      (upd_req),
        .upd_req_data (upd_req_data),
        .upd_rdy      (upd_rdy),
        .upd_ack      (upd_ack),
        .upd_rsp      (upd_rsp),
        .qry_req      (qry_req),
        .qry_req_data (qry_req_data),
        .qry_rdy      (qry_rdy),
        .qry_ack      (qry_ack),
        .qry_rsp      (qry_rsp)
    );

endmodule : db_subsystem

// File: verif/tb_clkgen.sv
/* Free-running testbench clock, starts low */

`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule : tb_clkgen

// File: verif/db_subsystem_assertions.sv
/* Handshake assertions on the four client channels of the lookup table.
   Bound into the top level from the testbench. */

`timescale 1ns/1ps

module db_subsystem_assertions
    import db_pkg::*;
(
    input logic clk,
    input logic srst,
    input logic cpu_upd_req,
    input logic cpu_upd_rdy,
    input logic cpu_upd_ack,
    input logic eng_upd_req,
    input logic eng_upd_rdy,
    input logic eng_upd_ack,
    input logic cpu_qry_req,
    input logic cpu_qry_rdy,
    input logic cpu_qry_ack,
    input logic eng_qry_req,
    input logic eng_qry_rdy,
    input logic eng_qry_ack
);

    // Number of assertion failures so far
    int unsigned fail_count = 0;

    // Cycles since reset release, saturates at the sweep length
    int unsigned since_rst;

    function automatic void log_failure(input string msg);
        $error("%s", msg);
        fail_count++;
    endfunction

    always_ff @(posedge clk) begin
        if (srst) begin
            since_rst <= 0;
        end else if (since_rst < DB_DEPTH) begin
            since_rst <= since_rst + 1;
        end
    end

    // ======================================================================
    // Properties
    // ======================================================================

    property req_held(req, rdy);
        @(posedge clk) disable iff (srst) req && !rdy |=> req;
    endproperty

    // An ack cycle stands for exactly one acceptance two cycles earlier
    property ack_matches_accept(req, rdy, ack);
        @(posedge clk) disable iff (srst) ack |-> $past(req && rdy, 2);
    endproperty

    a_cpu_upd_held : assert property (req_held(cpu_upd_req, cpu_upd_rdy))
        else log_failure("cpu update req dropped before rdy");
    a_eng_upd_held : assert property (req_held(eng_upd_req, eng_upd_rdy))
        else log_failure("engine update req dropped before rdy");
    a_cpu_qry_held : assert property (req_held(cpu_qry_req, cpu_qry_rdy))
        else log_failure("cpu query req dropped before rdy");
    a_eng_qry_held : assert property (req_held(eng_qry_req, eng_qry_rdy))
        else log_failure("engine query req dropped before rdy");

    a_cpu_upd_ack : assert property (ack_matches_accept(cpu_upd_req, cpu_upd_rdy, cpu_upd_ack))
        else log_failure("cpu update ack without an acceptance two cycles before");
    a_eng_upd_ack : assert property (ack_matches_accept(eng_upd_req, eng_upd_rdy, eng_upd_ack))
        else log_failure("engine update ack without an acceptance two cycles before");
    a_cpu_qry_ack : assert property (ack_matches_accept(cpu_qry_req, cpu_qry_rdy, cpu_qry_ack))
        else log_failure("cpu query ack without an acceptance two cycles before");
    a_eng_qry_ack : assert property (ack_matches_accept(eng_qry_req, eng_qry_rdy, eng_qry_ack))
        else log_failure("engine query ack without an acceptance two cycles before");

    // Table is still being cleared
    a_no_rdy_in_sweep : assert property (
        @(posedge clk) disable iff (srst)
        since_rst < DB_DEPTH |-> !(cpu_upd_rdy || eng_upd_rdy || cpu_qry_rdy || eng_qry_rdy)
    ) else log_failure("rdy high during the clearing sweep");

endmodule : db_subsystem_assertions

// File: verif/db_subsystem_tb.sv
/* Random-stimulus testbench for the lookup table. Drives both clients on both
   channels and checks every ack against a reference model of the table. */

`timescale 1ns/1ps

module db_subsystem_tb
    import db_pkg::*;
();

    // Expected response of one accepted request
    typedef struct packed {
        logic [31:0] cycle;
        logic        error;
        logic        valid;
        value_t      value;
    } exp_t;

    // ======================================================================
    // Signals per client (index 0 cpu, index 1 packet engine)
    // ======================================================================

    logic clk;
    logic srst;

    logic [1:0] upd_req;
    upd_req_t   upd_data [2];
    wire  [1:0] upd_rdy;
    wire  [1:0] upd_ack;
    wire  [1:0] upd_err;

    logic [1:0] qry_req;
    key_t       qry_key [2];
    wire  [1:0] qry_rdy;
    wire  [1:0] qry_ack;
    wire  [1:0] qry_err;
    wire  [1:0] qry_vld;
    wire  [VALUE_W-1:0] qry_val [2];

    logic [31:0]      rng_state = 32'h1853_8e5d;
    logic [VALUE_W:0] model [int];

    // Requests waiting to be driven, and responses still owed
    upd_req_t upd_send [2][$];
    qry_req_t qry_send [2][$];
    exp_t     upd_exp [2][$];
    exp_t     qry_exp [2][$];

    logic [1:0] upd_acc = '0;
    logic [1:0] qry_acc = '0;
    logic       gaps_on = 1'b0;
    int         cycle = 0;
    int         rdy_cycle = -1;

    tb_clkgen #(.PERIOD_NS(100)) u_clkgen (.clk(clk));

    db_subsystem dut (
        .clk           (clk),
        .srst          (srst),
        .cpu_upd_req   (upd_req[0]),
        .cpu_upd_key   (upd_data[0].key),
        .cpu_upd_valid (upd_data[0].valid),
        .cpu_upd_value (upd_data[0].value),
        .cpu_upd_rdy   (upd_rdy[0]),
        .cpu_upd_ack   (upd_ack[0]),
        .cpu_upd_error (upd_err[0]),
        .eng_upd_req   (upd_req[1]),
        .eng_upd_key   (upd_data[1].key),
        .eng_upd_valid (upd_data[1].valid),
        .eng_upd_value (upd_data[1].value),
        .eng_upd_rdy   (upd_rdy[1]),
        .eng_upd_ack   (upd_ack[1]),
        .eng_upd_error (upd_err[1]),
        .cpu_qry_req   (qry_req[0]),
        .cpu_qry_key   (qry_key[0]),
        .cpu_qry_rdy   (qry_rdy[0]),
        .cpu_qry_ack   (qry_ack[0]),
        .cpu_qry_error (qry_err[0]),
        .cpu_qry_valid (qry_vld[0]),
        .cpu_qry_value (qry_val[0]),
        .eng_qry_req   (qry_req[1]),
        .eng_qry_key   (qry_key[1]),
        .eng_qry_rdy   (qry_rdy[1]),
        .eng_qry_ack   (qry_ack[1]),
        .eng_qry_error (qry_err[1]),
        .eng_qry_valid (qry_vld[1]),
        .eng_qry_value (qry_val[1])
    );

    bind db_subsystem db_subsystem_assertions u_assertions (.*);

    // ======================================================================
    // Helpers
    // ======================================================================

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic string who(input int c);
        return (c == 0) ? "cpu" : "engine";
    endfunction

    function automatic key_t in_range_key();
        return key_t'(next_rand() % DB_DEPTH);
    endfunction

    function automatic key_t out_of_range_key();
        return key_t'(DB_DEPTH + next_rand() % ((1 << KEY_W) - DB_DEPTH));
    endfunction

    // Keys come half from the whole key space and half from a small colliding pool
    function automatic key_t random_key();
        logic [31:0] r;
        r = next_rand();
        if (r[31]) begin
            return r[7:0];
        end
        return key_t'(r[10:8]);
    endfunction

    task automatic report_failure();
        $display("TEST FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check(input string what, input logic [63:0] got,
                         input logic [63:0] expected);
        if (got !== expected) begin
            $display("mismatch at %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, what, got, expected);
            report_failure();
        end
    endtask

    task automatic push_update(input int c, input key_t k);
        upd_req_t u;
        u.key   = k;
        u.valid = (next_rand() % 4 != 0);
        u.value = next_rand();
        upd_send[c].push_back(u);
    endtask

    task automatic push_query(input int c, input key_t k);
        qry_req_t q;
        q.key = k;
        qry_send[c].push_back(q);
    endtask

    function automatic bit all_idle();
        for (int c = 0; c < 2; c++) begin
            if (upd_send[c].size() != 0 || qry_send[c].size() != 0 ||
                upd_exp[c].size() != 0 || qry_exp[c].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic wait_idle(input string what, input int limit);
        int n;
        n = 0;
        while (!all_idle()) begin
            if (n == limit) begin
                $display("timeout: %s still busy after %0d cycles", what, limit);
                report_failure();
            end else begin
                @(posedge clk);
                n++;
            end
        end
    endtask

    // ======================================================================
    // Reference model
    // ======================================================================

    task automatic record_query(input int c);
        exp_t e;
        key_t k;
        qry_acc[c] = qry_req[c] && qry_rdy[c];
        if (qry_acc[c]) begin
            k = qry_key[c];
            e = '0;
            e.cycle = cycle;
            e.error = (k >= DB_DEPTH);
            if (!e.error && model.exists(int'(k))) begin
                {e.valid, e.value} = model[int'(k)];
            end
            qry_exp[c].push_back(e);
        end
    endtask

    task automatic record_update(input int c);
        exp_t e;
        key_t k;
        upd_acc[c] = upd_req[c] && upd_rdy[c];
        if (upd_acc[c]) begin
            k = upd_data[c].key;
            e = '0;
            e.cycle = cycle;
            e.error = (k >= DB_DEPTH);
            // Out-of-range keys never touch the table
            if (!e.error) begin
                model[int'(k)] = {upd_data[c].valid, upd_data[c].value};
            end
            upd_exp[c].push_back(e);
        end
    endtask

    task automatic retire_update(input int c);
        exp_t e;
        if (upd_ack[c]) begin
            if (upd_exp[c].size() == 0) begin
                $display("%s got an update ack at time %0t with no update outstanding",
                         who(c), $time);
                report_failure();
            end else begin
                e = upd_exp[c].pop_front();
                check({who(c), " update ack latency"}, cycle - e.cycle, 2);
                check({who(c), " update error"}, upd_err[c], e.error);
            end
        end
    endtask

    task automatic retire_query(input int c);
        exp_t e;
        if (qry_ack[c]) begin
            if (qry_exp[c].size() == 0) begin
                $display("%s got a query ack at time %0t with no query outstanding",
                         who(c), $time);
                report_failure();
            end else begin
                e = qry_exp[c].pop_front();
                check({who(c), " query ack latency"}, cycle - e.cycle, 2);
                check({who(c), " query error"}, qry_err[c], e.error);
                check({who(c), " query valid"}, qry_vld[c], e.valid);
                check({who(c), " query value"}, qry_val[c], e.value);
            end
        end
    endtask

    task automatic check_priority(input string chan, input logic [1:0] req,
                                  input logic [1:0] rdy);
        if (req[0]) begin
            check({"cpu ", chan, " rdy while requesting"}, rdy[0], 1'b1);
        end
        if (req[1] && rdy[1]) begin
            check({"engine ", chan, " accepted over a cpu request"}, req[0], 1'b0);
        end
    endtask

    // Sampled mid-cycle where inputs and outputs are both settled
    always @(negedge clk) begin : monitor
        if (!srst) begin
            if (rdy_cycle < 0 && (upd_rdy != 0 || qry_rdy != 0)) begin
                rdy_cycle = cycle;
            end
            if (cycle < DB_DEPTH) begin
                check("rdy during the clearing sweep", {upd_rdy, qry_rdy}, 0);
            end else begin
                check_priority("update", upd_req, upd_rdy);
                check_priority("query", qry_req, qry_rdy);
            end
            // Queries go first so a same-cycle update is not visible to them yet
            for (int c = 0; c < 2; c++) begin
                record_query(c);
            end
            for (int c = 0; c < 2; c++) begin
                record_update(c);
                retire_update(c);
                retire_query(c);
            end
            cycle++;
        end
    end

    always @(negedge clk) begin : assertion_watch
        if (dut.u_assertions.fail_count != 0) begin
            $display("protocol assertion failed before time %0t", $time);
            report_failure();
        end
    end

    // ======================================================================
    // Client drivers
    // ======================================================================

    function automatic bit send_now();
        return !gaps_on || (next_rand() % 4 != 0);
    endfunction

    always begin : driver
        @(posedge clk);
        #5;
        for (int c = 0; c < 2; c++) begin
            if (upd_acc[c]) begin
                void'(upd_send[c].pop_front());
                upd_req[c] = 1'b0;
            end
            if (!upd_req[c] && upd_send[c].size() != 0 && send_now()) begin
                upd_req[c]  = 1'b1;
                upd_data[c] = upd_send[c][0];
            end
            if (qry_acc[c]) begin
                void'(qry_send[c].pop_front());
                qry_req[c] = 1'b0;
            end
            if (!qry_req[c] && qry_send[c].size() != 0 && send_now()) begin
                qry_req[c] = 1'b1;
                qry_key[c] = qry_send[c][0].key;
            end
        end
    end

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin : main
        int   n;
        key_t k;
        srst    = 1'b1;
        upd_req = '0;
        qry_req = '0;
        for (int c = 0; c < 2; c++) begin
            upd_data[c] = '0;
            qry_key[c]  = '0;
        end
        repeat (16) @(posedge clk);
        #5;
        srst = 1'b0;

        // Every client requests while the sweep runs and must wait for it
        for (int c = 0; c < 2; c++) begin
            push_update(c, out_of_range_key());
        end
        for (int i = 0; i < DB_DEPTH; i++) begin
            push_query(i % 2, key_t'(i));
        end
        n = 0;
        while (rdy_cycle < 0) begin
            if (n == 400) begin
                $display("timeout: no rdy within 400 cycles after reset");
                report_failure();
            end else begin
                @(posedge clk);
                n++;
            end
        end
        check("first rdy cycle after reset", rdy_cycle, DB_DEPTH);
        wait_idle("query of every cleared entry", 1000);

        // Update then query of the same key
        for (int i = 0; i < 16; i++) begin
            k = in_range_key();
            push_update(i % 2, k);
            wait_idle("single update", 20);
            push_query(int'(next_rand() % 2), k);
            wait_idle("query after update", 20);
        end

        // Out-of-range keys
        for (int i = 0; i < 16; i++) begin
            k = out_of_range_key();
            push_update(i % 2, k);
            push_query((i + 1) % 2, k);
            wait_idle("out-of-range access", 20);
        end

        // Both clients requesting without gaps
        gaps_on = 1'b0;
        for (int i = 0; i < 32; i++) begin
            for (int c = 0; c < 2; c++) begin
                push_update(c, in_range_key());
                push_query(c, in_range_key());
            end
        end
        wait_idle("priority traffic", 500);

        // Random overlapping traffic
        gaps_on = 1'b1;
        for (int i = 0; i < 300; i++) begin
            push_update(int'(next_rand() % 2), random_key());
            push_query(int'(next_rand() % 2), random_key());
        end
        wait_idle("random overlapping traffic", 4000);

        if (dut.u_assertions.fail_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("protocol assertion failed during the run");
            report_failure();
        end
    end

endmodule : db_subsystem_tb

// File: verilog.f
common/db_pkg.sv
design/db_prio_mux.sv
db_store/db_store.sv
design/db_subsystem.sv
verif/tb_clkgen.sv
verif/db_subsystem_assertions.sv
verif/db_subsystem_tb.sv
